/* design/pll_cfg_pkg.sv */
// Shared definitions for the PLL reconfiguration controller
// Bus widths and management register addresses
// Divider tables for the CPU and UART PLL outputs
// Nominal CPU clock rate table
// Command queue sizing and the sequencer step type

`default_nettype none

package pll_cfg_pkg;

	// --------------------
	// Widths
	localparam int cfg_addr_w   = 6;
	localparam int cfg_data_w   = 32;
	localparam int cpu_speed_w  = 3;
	localparam int uart_speed_w = 2;
	localparam int rate_w       = 28;

	// --------------------
	// Management register map
	localparam logic [cfg_addr_w-1:0] addr_mode    = 6'd0;
	localparam logic [cfg_addr_w-1:0] addr_counter = 6'd5;
	localparam logic [cfg_addr_w-1:0] addr_start   = 6'd2;

	// --------------------
	// Counter settings, indexed by the requested speed
	// Top half of the CPU table is the overclock setting
	localparam logic [cfg_data_w-1:0] cpu_div_table [8] = '{
		32'h0000_0505, 32'h0000_1E1E, 32'h0000_0F0F, 32'h0000_0808,
		32'h0002_0504, 32'h0002_0504, 32'h0002_0504, 32'h0002_0504
	};

	// Normal rate, MIDI rate, then the fast serial setting
	localparam logic [cfg_data_w-1:0] uart_div_table [4] = '{
		32'h0004_0909, 32'h0004_F4F4, 32'h0004_9696, 32'h0004_9696
	};

	// CPU clock in Hz for each speed
	localparam logic [rate_w-1:0] clk_rate_table [8] = '{
		28'd90_000_000, 28'd15_000_000, 28'd30_000_000, 28'd56_250_000,
		28'd100_000_000, 28'd100_000_000, 28'd100_000_000, 28'd100_000_000
	};

	// --------------------
	// Command queue
	localparam int fifo_depth = 4;
	localparam int fifo_ptr_w = $clog2(fifo_depth);
	localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

	// One step per management write, plus idle
	typedef enum logic [2:0] {
		step_idle,
		step_mode,
		step_cpu_div,
		step_uart_div,
		step_start
	} seq_step_t;

endpackage

`default_nettype wire

/* design/cfg_cmd_if.sv */
// Valid/ready channel carrying one management-port write command
// Source side drives the command, sink side drives ready

`timescale 1ns/1ns
`default_nettype none

interface cfg_cmd_if;
	import pll_cfg_pkg::*;

	logic                  valid;
	logic                  ready;
	logic [cfg_addr_w-1:0] addr;
	logic [cfg_data_w-1:0] data;

	// Producer of commands
	modport source (
		output valid,
		output addr,
		output data,
		input  ready
	);

	// Consumer of commands
	modport sink (
		input  valid,
		input  addr,
		input  data,
		output ready
	);

endinterface

`default_nettype wire

/* design/speed_sync.sv */
// Two-stage synchronizer with a stability filter for a speed request

`timescale 1ns/1ns
`default_nettype none

module speed_sync #(
	parameter int width = 1
) (
	input  logic             clk_sys,
	input  logic             cpu_reset,
	input  logic [width-1:0] req,
	output logic [width-1:0] speed
);

	logic [width-1:0] sp1;
	logic [width-1:0] sp2;

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			sp1   <= '0;
			sp2   <= '0;
			speed <= '0;
		end else begin
			sp1 <= req;
			sp2 <= sp1;
			// Only pass a value seen on two consecutive samples
			if (sp2 == sp1) begin
				speed <= sp2;
			end
		end
	end

endmodule

`default_nettype wire

/* design/reconfig_sequencer.sv */
// Reconfiguration sequencer
// Watches the filtered speed requests and the reset release
// Issues mode, CPU counter, UART counter and start writes in order
// Holds the nominal CPU clock rate for the programmed speed

`timescale 1ns/1ns
`default_nettype none

module reconfig_sequencer (
	input  logic                               clk_sys,
	input  logic                               cpu_reset,
	input  logic [pll_cfg_pkg::cpu_speed_w-1:0]  cpu_speed,
	input  logic [pll_cfg_pkg::uart_speed_w-1:0] uart_speed,
	input  logic                               pll_locked,
	cfg_cmd_if.source                          cmd,
	output logic [pll_cfg_pkg::rate_w-1:0]       clock_rate
);
	import pll_cfg_pkg::*;

	seq_step_t               step;
	logic [cpu_speed_w-1:0]  cur_cpu;
	logic [uart_speed_w-1:0] cur_uart;
	logic                    rst_d;
	logic                    rst_fell;
	logic                    speed_diff;
	logic                    start;
	logic                    xfer;

	assign rst_fell   = rst_d & ~cpu_reset;
	assign speed_diff = (cpu_speed != cur_cpu) || (uart_speed != cur_uart);
	assign start      = (step == step_idle) && pll_locked && (speed_diff || rst_fell);
	assign xfer       = cmd.valid && cmd.ready;

	// --------------------
	// Step FSM
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			step       <= step_idle;
			cmd.valid  <= 1'b0;
			cur_cpu    <= '0;
			cur_uart   <= '0;
			rst_d      <= 1'b1;
			clock_rate <= clk_rate_table[0];
		end else begin
			rst_d <= cpu_reset;
			case (step)
				step_idle: begin
					if (start) begin
						// Latch the newest request for the whole sequence
						cur_cpu    <= cpu_speed;
						cur_uart   <= uart_speed;
						clock_rate <= clk_rate_table[cpu_speed];
						cmd.valid  <= 1'b1;
						cmd.addr   <= addr_mode;
						cmd.data   <= '0;
						step       <= step_mode;
					end
				end
				step_mode: begin
					if (xfer) begin
						cmd.addr <= addr_counter;
						cmd.data <= cpu_div_table[cur_cpu];
						step     <= step_cpu_div;
					end
				end
				step_cpu_div: begin
					if (xfer) begin
						cmd.addr <= addr_counter;
						cmd.data <= uart_div_table[cur_uart];
						step     <= step_uart_div;
					end
				end
				step_uart_div: begin
					if (xfer) begin
						cmd.addr <= addr_start;
						cmd.data <= '0;
						step     <= step_start;
					end
				end
				step_start: begin
					// Back to idle, a pending change is picked up there
					if (xfer) begin
						cmd.valid <= 1'b0;
						step      <= step_idle;
					end
				end
				default: begin
					cmd.valid <= 1'b0;
					step      <= step_idle;
				end
			endcase
		end
	end

	// Offered command holds until the queue takes it
	assert property (@(posedge clk_sys) disable iff (cpu_reset)
		cmd.valid && !cmd.ready |=> cmd.valid && $stable(cmd.addr) && $stable(cmd.data));

endmodule

`default_nettype wire

/* design/cfg_cmd_fifo.sv */
// Command queue between the sequencer and the management-port driver
// Circular buffer with read and write pointers and an entry count

`timescale 1ns/1ns
`default_nettype none

module cfg_cmd_fifo (
	input  logic      clk_sys,
	input  logic      cpu_reset,
	cfg_cmd_if.sink   wr,
	cfg_cmd_if.source rd
);
	import pll_cfg_pkg::*;

	logic [cfg_addr_w-1:0] addr_mem [fifo_depth];
	logic [cfg_data_w-1:0] data_mem [fifo_depth];
	logic [fifo_ptr_w-1:0] wr_ptr;
	logic [fifo_ptr_w-1:0] rd_ptr;
	logic [fifo_cnt_w-1:0] count;
	logic                  push;
	logic                  pop;

	assign wr.ready = (count < fifo_cnt_w'(fifo_depth));
	assign rd.valid = (count != '0);
	assign rd.addr  = addr_mem[rd_ptr];
	assign rd.data  = data_mem[rd_ptr];

	assign push = wr.valid && wr.ready;
	assign pop  = rd.valid && rd.ready;

	// --------------------
	// Storage
	always_ff @(posedge clk_sys) begin
		if (push) begin
			addr_mem[wr_ptr] <= wr.addr;
			data_mem[wr_ptr] <= wr.data;
		end
	end

	// --------------------
	// Pointers and count
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assert property (@(posedge clk_sys) disable iff (cpu_reset)
		count <= fifo_cnt_w'(fifo_depth));

	// Output only offers a command while the pointers hold one
	assert property (@(posedge clk_sys) disable iff (cpu_reset)
		rd.valid |-> (rd_ptr != wr_ptr) || (count == fifo_cnt_w'(fifo_depth)));

endmodule

`default_nettype wire

/* design/mgmt_port_driver.sv */
// PLL management-port driver
// Holds one command and keeps the write asserted while waitrequest is high

`timescale 1ns/1ns
`default_nettype none

module mgmt_port_driver (
	input  logic                              clk_sys,
	input  logic                              cpu_reset,
	cfg_cmd_if.sink                           cmd,
	input  logic                              cfg_waitrequest,
	output logic                              cfg_write,
	output logic [pll_cfg_pkg::cfg_addr_w-1:0] cfg_address,
	output logic [pll_cfg_pkg::cfg_data_w-1:0] cfg_data
);

	// Free when idle, or when the current write is accepted this cycle
	assign cmd.ready = !cfg_write || !cfg_waitrequest;

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			cfg_write <= 1'b0;
		end else if (cmd.valid && cmd.ready) begin
			cfg_write <= 1'b1;
		end else if (cfg_write && !cfg_waitrequest) begin
			cfg_write <= 1'b0;
		end
	end

	// Payload
	always_ff @(posedge clk_sys) begin
		if (cmd.valid && cmd.ready) begin
			cfg_address <= cmd.addr;
			cfg_data    <= cmd.data;
		end
	end

	// A stalled write keeps its address and data on the port
	assert property (@(posedge clk_sys) disable iff (cpu_reset)
		cfg_write && cfg_waitrequest |=> cfg_write && $stable(cfg_address) && $stable(cfg_data));

endmodule

`default_nettype wire

/* design/pll_reconfig_top.sv */
// PLL reconfiguration controller top level
// Request synchronizers, sequencer, command queue and port driver

`timescale 1ns/1ns
`default_nettype none

module pll_reconfig_top (
	input  logic                               clk_sys,
	input  logic                               cpu_reset,
	input  logic [pll_cfg_pkg::cpu_speed_w-1:0]  cpu_speed_req,
	input  logic [pll_cfg_pkg::uart_speed_w-1:0] uart_speed_req,
	input  logic                               pll_locked,
	input  logic                               cfg_waitrequest,
	output logic                               cfg_write,
	output logic [pll_cfg_pkg::cfg_addr_w-1:0]  cfg_address,
	output logic [pll_cfg_pkg::cfg_data_w-1:0]  cfg_data,
	output logic [pll_cfg_pkg::rate_w-1:0]      clock_rate
);
	import pll_cfg_pkg::*;

	logic [cpu_speed_w-1:0]  cpu_speed;
	logic [uart_speed_w-1:0] uart_speed;

	cfg_cmd_if seq_to_fifo ();
	cfg_cmd_if fifo_to_port ();

	// --------------------
	// Request filtering
	speed_sync #(.width(cpu_speed_w)) cpu_sync (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.req       (cpu_speed_req),
		.speed     (cpu_speed)
	);

	speed_sync #(.width(uart_speed_w)) uart_sync (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.req       (uart_speed_req),
		.speed     (uart_speed)
	);

	// --------------------
	// Command path
	reconfig_sequencer u_sequencer (
		.clk_sys    (clk_sys),
		.cpu_reset  (cpu_reset),
		.cpu_speed  (cpu_speed),
		.uart_speed (uart_speed),
		.pll_locked (pll_locked),
		.cmd        (seq_to_fifo.source),
		.clock_rate (clock_rate)
	);

	cfg_cmd_fifo u_fifo (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.wr        (seq_to_fifo.sink),
		.rd        (fifo_to_port.source)
	);

	mgmt_port_driver u_driver (
		.clk_sys         (clk_sys),
		.cpu_reset       (cpu_reset),
		.cmd             (fifo_to_port.sink),
		.cfg_waitrequest (cfg_waitrequest),
		.cfg_write       (cfg_write),
		.cfg_address     (cfg_address),
		.cfg_data        (cfg_data)
	);

endmodule

`default_nettype wire

/* verif/tb_pll_reconfig.sv */
// Directed testbench for the PLL reconfiguration controller
// PLL management-port model with random waitrequest and a write log
// Tests for reset release, speed sweeps, back-pressure, glitches and lock
// Watchdog bounding the whole run

`timescale 1ns/1ns
`default_nettype none

module tb_pll_reconfig;
	import pll_cfg_pkg::*;

	localparam int clk_period   = 8;
	localparam int seq_cycles   = 200;
	localparam int quiet_cycles = 24;
	localparam int num_seqs     = 16;
	localparam int watchdog_ns  =
		(num_seqs * (seq_cycles + quiet_cycles) + 3 * quiet_cycles + 120) * clk_period;
	localparam int log_w        = cfg_addr_w + cfg_data_w;

	// Expected PLL settings per requested speed
	localparam logic [31:0] cpu_div [8] = '{
		32'h0505, 32'h1E1E, 32'h0F0F, 32'h0808,
		32'h20504, 32'h20504, 32'h20504, 32'h20504
	};
	localparam logic [31:0] uart_div [4] = '{32'h40909, 32'h4F4F4, 32'h49696, 32'h49696};
	localparam logic [27:0] cpu_rate [8] = '{
		28'd90_000_000, 28'd15_000_000, 28'd30_000_000, 28'd56_250_000,
		28'd100_000_000, 28'd100_000_000, 28'd100_000_000, 28'd100_000_000
	};

	logic                    clk_sys;
	logic                    cpu_reset;
	logic [cpu_speed_w-1:0]  cpu_speed_req;
	logic [uart_speed_w-1:0] uart_speed_req;
	logic                    pll_locked;
	logic                    cfg_waitrequest;
	logic                    cfg_write;
	logic [cfg_addr_w-1:0]   cfg_address;
	logic [cfg_data_w-1:0]   cfg_data;
	logic [rate_w-1:0]       clock_rate;

	int               seed = 32'h007755c1;
	int               rnd;
	int               rd_idx;
	logic             bp_en;
	logic             stalled;
	logic [log_w-1:0] stall_word;
	logic [log_w-1:0] wr_log [$];

	pll_reconfig_top DUT (
		.clk_sys         (clk_sys),
		.cpu_reset       (cpu_reset),
		.cpu_speed_req   (cpu_speed_req),
		.uart_speed_req  (uart_speed_req),
		.pll_locked      (pll_locked),
		.cfg_waitrequest (cfg_waitrequest),
		.cfg_write       (cfg_write),
		.cfg_address     (cfg_address),
		.cfg_data        (cfg_data),
		.clock_rate      (clock_rate)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("=== FAIL ===");
		$fatal(1, "Run stopped");
	endtask

	// --------------------
	// PLL model
	initial begin
		cfg_waitrequest = 1'b0;
		forever begin
			@(negedge clk_sys);
			rnd = $random(seed);
			cfg_waitrequest = bp_en && rnd[0];
		end
	end

	// Log accepted writes and check that stalled writes hold
	always @(posedge clk_sys) begin
		if (cpu_reset) begin
			stalled = 1'b0;
		end else begin
			if (stalled) begin
				assert ({cfg_address, cfg_data} == stall_word) else
					stop_run($sformatf("** Error at %0t ns: stalled write changed from %h to %h",
						$time, stall_word, {cfg_address, cfg_data}));
			end
			if (cfg_write && !cfg_waitrequest) begin
				wr_log.push_back({cfg_address, cfg_data});
			end
			stalled    = cfg_write && cfg_waitrequest;
			stall_word = {cfg_address, cfg_data};
		end
	end

	// --------------------
	// Helpers
	task automatic wait_writes(input int n, input string what);
		int cycles;
		cycles = 0;
		while ((wr_log.size() - rd_idx < n) && (cycles < seq_cycles)) begin
			@(negedge clk_sys);
			cycles++;
		end
		assert (wr_log.size() - rd_idx >= n) else
			stop_run($sformatf("The %s sequence did not finish within %0d cycles",
				what, seq_cycles));
	endtask

	// No further writes may show up
	task automatic expect_quiet(input int n);
		repeat (quiet_cycles) @(negedge clk_sys);
		assert (wr_log.size() - rd_idx == n) else
			stop_run($sformatf("** Error at %0t ns: expected %0d pending writes, saw %0d",
				$time, n, wr_log.size() - rd_idx));
	endtask

	task automatic check_sequence(input logic [2:0] cpu, input logic [1:0] uart);
		logic [log_w-1:0] exp [4];
		int               i;
		exp[0] = {6'd0, 32'd0};
		exp[1] = {6'd5, cpu_div[cpu]};
		exp[2] = {6'd5, uart_div[uart]};
		exp[3] = {6'd2, 32'd0};
		for (i = 0; i < 4; i++) begin
			assert (wr_log[rd_idx] == exp[i]) else
				stop_run($sformatf("** Error at %0t ns: write %0d got %h:%h, expected %h:%h",
					$time, i, wr_log[rd_idx][log_w-1 -: cfg_addr_w],
					wr_log[rd_idx][cfg_data_w-1:0], exp[i][log_w-1 -: cfg_addr_w],
					exp[i][cfg_data_w-1:0]));
			rd_idx++;
		end
		assert (clock_rate == cpu_rate[cpu]) else
			stop_run($sformatf("** Error at %0t ns: clock_rate %0d, expected %0d",
				$time, clock_rate, cpu_rate[cpu]));
	endtask

	task automatic program_speeds(input logic [2:0] cpu, input logic [1:0] uart,
		input string what);
		@(negedge clk_sys);
		cpu_speed_req  = cpu;
		uart_speed_req = uart;
		wait_writes(4, what);
		expect_quiet(4);
		check_sequence(cpu, uart);
	endtask

	// --------------------
	// Tests
	task automatic reset_release();
		repeat (8) @(negedge clk_sys);
		cpu_reset = 1'b0;
		wait_writes(4, "reset release");
		expect_quiet(4);
		check_sequence(3'd0, 2'd0);
	endtask

	task automatic cpu_speed_sweep();
		int s;
		for (s = 1; s < 8; s++) begin
			program_speeds(3'(s), 2'd0, "CPU speed");
		end
	endtask

	task automatic uart_speed_sweep();
		int u;
		for (u = 1; u < 4; u++) begin
			program_speeds(3'd7, 2'(u), "UART speed");
		end
	endtask

	task automatic back_pressure();
		bp_en = 1'b1;
		program_speeds(3'd2, 2'd1, "stalled");
		program_speeds(3'd0, 2'd3, "stalled");
		program_speeds(3'd5, 2'd2, "stalled");
		program_speeds(3'd3, 2'd0, "stalled");
		bp_en = 1'b0;
	endtask

	task automatic glitch_and_lock();
		// One-cycle pulse is filtered out
		@(negedge clk_sys);
		cpu_speed_req = 3'd6;
		@(negedge clk_sys);
		cpu_speed_req = 3'd3;
		expect_quiet(0);
		pll_locked    = 1'b0;
		cpu_speed_req = 3'd1;
		expect_quiet(0);
		uart_speed_req = 2'd2;
		expect_quiet(0);
		pll_locked = 1'b1;
		wait_writes(4, "lock");
		expect_quiet(4);
		check_sequence(3'd1, 2'd2);
	endtask

	initial begin
		cpu_reset      = 1'b1;
		cpu_speed_req  = '0;
		uart_speed_req = '0;
		pll_locked     = 1'b1;
		bp_en          = 1'b0;
		rd_idx         = 0;
		reset_release();
		cpu_speed_sweep();
		uart_speed_sweep();
		back_pressure();
		glitch_and_lock();
		$display("=== PASS ===");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		stop_run($sformatf("Watchdog expired after %0d ns, a test is stuck", watchdog_ns));
	end

endmodule

`default_nettype wire

/* list.f */
design/pll_cfg_pkg.sv
design/cfg_cmd_if.sv
design/speed_sync.sv
design/reconfig_sequencer.sv
design/cfg_cmd_fifo.sv
design/mgmt_port_driver.sv
design/pll_reconfig_top.sv
verif/tb_pll_reconfig.sv

/* Makefile */
# Verilator build and run for the PLL reconfiguration controller

TOP             ?= tb_pll_reconfig
RTL_TOP         ?= pll_reconfig_top
FILELIST        ?= list.f
VERILATOR       ?= verilator
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS      ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
